/* rv32_exec_core.f */
+incdir+rtl
rtl/rv32_pkg.sv
rtl/rv32_control_unit.sv
rtl/rv32_reg_file.sv
rtl/rv32_operand_stage.sv
rtl/rv32_execute_stage.sv
rtl/rv32_exec_core.sv
test/tb_rv32_exec_core.sv

/* Bender.yml */
package:
  name: rv32_exec_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv32_pkg.sv
      - rtl/rv32_control_unit.sv
      - rtl/rv32_reg_file.sv
      - rtl/rv32_operand_stage.sv
      - rtl/rv32_execute_stage.sv
      - rtl/rv32_exec_core.sv
      - target: test
        files:
          - test/tb_rv32_exec_core.sv

/* test/tb_rv32_exec_core.sv */
/*
 * Testbench for the RV32 execute core. Feeds random instruction streams
 * from a fixed seed, predicts every retire record with a reference model
 * and checks contents, order and the three-cycle latency.
 */

`include "rv32_defines.svh"

module tb_rv32_exec_core
  import rv32_pkg::*;
();

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 3;
  localparam int NUM_TESTS     = 6;
  localparam int TEST_LEN      = 200;
  localparam int WATCHDOG_TIME = (NUM_TESTS * TEST_LEN * 2 + RESET_CYCLES + 10) * CLK_PERIOD;

  // Stimulus kinds
  localparam int K_ALU     = 0;
  localparam int K_DEP     = 1;
  localparam int K_CTRL    = 2;
  localparam int K_MEMSYS  = 3;
  localparam int K_ILLEGAL = 4;
  localparam int K_MIX     = 5;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  instr_valid_i;
  logic [`RV32_XLEN-1:0] instr_i;
  logic [`RV32_XLEN-1:0] pc_i;
  retire_t               retire_o;

  integer                seed;
  int                    cycle;
  logic [`RV32_XLEN-1:0] regs_m [`RV32_NUM_REGS];
  logic [`RV32_XLEN-1:0] pc_next;
  logic [4:0]            last_rd;
  retire_t               exp_q [$];
  int                    due_q [$];

  rv32_exec_core i_rv32_exec_core (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .retire_o      (retire_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  initial begin
    #(WATCHDOG_TIME);
    fail_run("Watchdog expired before all tests finished");
  end

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] rnd_word();
    return $random(seed);
  endfunction

  // Small register set so that sources often hit recent destinations
  function automatic logic [4:0] rand_reg();
    return 5'(rnd(8));
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] opc);
    rtype_t r;
    r.funct7 = f7;
    r.rs2    = rs2;
    r.rs1    = rs1;
    r.funct3 = f3;
    r.rd     = rd;
    r.opcode = opc;
    return r;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic legal_opcode(input logic [6:0] opc);
    case (opc)
      7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011, 7'b0000011,
      7'b0100011, 7'b0010011, 7'b0110011, 7'b0001111, 7'b1110011: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                           input logic is_reg, input logic [31:0] a,
                                           input logic [31:0] b);
    case (f3)
      3'd0: return (is_reg && alt) ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return 32'($signed(a) < $signed(b));
      3'd3: return 32'(a < b);
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Reference model runs in program order as each strobe is driven
  task automatic model_exec(input logic [31:0] instr, input logic [31:0] pc,
                            output retire_t exp);
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    f3    = instr[14:12];
    a     = regs_m[instr[19:15]];
    b     = regs_m[instr[24:20]];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u = {instr[31:12], 12'b0};
    imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    exp.valid   = 1'b1;
    exp.pc      = pc;
    exp.rd      = instr[11:7];
    exp.wen     = 1'b0;
    exp.result  = a + imm_i;
    exp.taken   = 1'b0;
    exp.next_pc = pc + 32'd4;
    exp.ev      = EV_NONE;
    case (instr[6:0])
      OP_REGREG: begin
        exp.result = alu_model(f3, instr[30], 1'b1, a, b);
        if (instr[25]) begin
          exp.ev = EV_ILLEGAL;
        end else begin
          exp.wen = 1'b1;
        end
      end
      OP_IMMED: begin
        exp.result = alu_model(f3, instr[30], 1'b0, a, imm_i);
        exp.wen    = 1'b1;
      end
      OP_LUI: begin
        exp.result = imm_u;
        exp.wen    = 1'b1;
      end
      OP_AUIPC: begin
        exp.result = pc + imm_u;
        exp.wen    = 1'b1;
      end
      OP_JAL: begin
        exp.result  = pc + 32'd4;
        exp.next_pc = pc + imm_j;
        exp.taken   = 1'b1;
        exp.wen     = 1'b1;
      end
      OP_JALR: begin
        exp.result  = pc + 32'd4;
        exp.next_pc = (a + imm_i) & ~32'd1;
        exp.taken   = 1'b1;
        exp.wen     = 1'b1;
      end
      OP_BRANCH: begin
        exp.taken  = branch_model(f3, a, b);
        exp.result = pc + imm_b;
        if (exp.taken) begin
          exp.next_pc = pc + imm_b;
        end
      end
      OP_STORE: exp.result = a + imm_s;
      OP_LOAD, OP_MISCMEM: exp.result = a + imm_i;
      OP_SYSTEM: begin
        if (f3 == 3'd0) begin
          case (instr[31:20])
            12'h000: exp.ev = EV_ECALL;
            12'h001: exp.ev = EV_EBREAK;
            12'h302: exp.ev = EV_MRET;
            12'h105: exp.ev = EV_WFI;
            default: exp.ev = EV_NONE;
          endcase
        end else if (f3 != 3'd4) begin
          exp.ev = EV_CSR;
        end
      end
      default: exp.ev = EV_ILLEGAL;
    endcase
    if (exp.wen && exp.rd != '0) begin
      regs_m[exp.rd] = exp.result;
    end
  endtask

  task automatic gen_alu(input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
                         output logic [31:0] instr);
    int unsigned kind;
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] r;
    kind = rnd(8);
    f3   = 3'(rnd(8));
    alt  = 1'(rnd(2));
    r    = rnd_word();
    if (kind < 4) begin
      instr = enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                    rs2, rs1, f3, rd, OP_REGREG);
    end else if (kind < 7) begin
      // Shift immediates carry a funct7 in the upper bits
      if (f3 == 3'd1) begin
        r[11:5] = 7'h00;
      end else if (f3 == 3'd5) begin
        r[11:5] = alt ? 7'h20 : 7'h00;
      end
      instr = enc_i(r[11:0], rs1, f3, rd, OP_IMMED);
    end else begin
      instr = {r[19:0], rd, alt ? OP_LUI : OP_AUIPC};
    end
  endtask

  task automatic gen_ctrl(output logic [31:0] instr);
    int unsigned kind;
    logic [2:0]  f3;
    logic [4:0]  rs1;
    logic [31:0] r;
    kind = rnd(4);
    rs1  = rand_reg();
    r    = rnd_word();
    f3   = 3'(rnd(6));
    if (f3 >= 3'd2) begin
      f3 = f3 + 3'd2;
    end
    if (kind < 2) begin
      instr = enc_b({r[12:1], 1'b0}, (rnd(4) == 0) ? rs1 : rand_reg(), rs1, f3);
    end else if (kind == 2) begin
      instr = enc_j({r[20:1], 1'b0}, rand_reg());
    end else begin
      // Odd offsets check that bit 0 of the target is cleared
      instr = enc_i(r[11:0], rs1, 3'd0, rand_reg(), OP_JALR);
    end
  endtask

  task automatic gen_memsys(output logic [31:0] instr);
    logic [2:0]  f3;
    logic [31:0] r;
    r = rnd_word();
    case (rnd(9))
      0: begin
        f3 = 3'(rnd(5));
        if (f3 >= 3'd3) begin
          f3 = f3 + 3'd1;
        end
        instr = enc_i(r[11:0], rand_reg(), f3, rand_reg(), OP_LOAD);
      end
      1: instr = enc_s(r[11:0], rand_reg(), rand_reg(), 3'(rnd(3)));
      2: instr = enc_i(r[11:0], rand_reg(), 3'd0, rand_reg(), OP_MISCMEM);
      3: instr = enc_i(12'h000, 5'd0, 3'd0, 5'd0, OP_SYSTEM);
      4: instr = enc_i(12'h001, 5'd0, 3'd0, 5'd0, OP_SYSTEM);
      5: instr = enc_i(12'h302, 5'd0, 3'd0, 5'd0, OP_SYSTEM);
      6: instr = enc_i(12'h105, 5'd0, 3'd0, 5'd0, OP_SYSTEM);
      default: begin
        // CSR funct3 values 1..3 and 5..7
        f3 = 3'(rnd(6));
        f3 = f3 + ((f3 >= 3'd3) ? 3'd2 : 3'd1);
        instr = enc_i(r[11:0], rand_reg(), f3, rand_reg(), OP_SYSTEM);
      end
    endcase
  endtask

  task automatic gen_illegal(output logic [31:0] instr);
    logic [6:0]  opc;
    logic [31:0] r;
    r = rnd_word();
    case (rnd(3))
      0: begin
        do begin
          opc = 7'(rnd(128));
        end while (legal_opcode(opc));
        instr = {r[31:7], opc};
      end
      1: instr = enc_r(7'h01, rand_reg(), rand_reg(), 3'(rnd(8)), rand_reg(), OP_REGREG);
      // Legal reads show whether an illegal word touched the registers
      default: gen_alu(rand_reg(), rand_reg(), rand_reg(), instr);
    endcase
  endtask

  task automatic gen_instr(input int kind, output logic [31:0] instr);
    logic [4:0] rd_new;
    case (kind)
      K_ALU: gen_alu(rand_reg(), rand_reg(), rand_reg(), instr);
      K_DEP: begin
        rd_new = 5'(1 + rnd(7));
        gen_alu(last_rd, (rnd(2) == 0) ? last_rd : rand_reg(), rd_new, instr);
        last_rd = rd_new;
      end
      K_CTRL: gen_ctrl(instr);
      K_MEMSYS: gen_memsys(instr);
      K_ILLEGAL: gen_illegal(instr);
      default: begin
        case (rnd(4))
          0: gen_alu(rand_reg(), rand_reg(), rand_reg(), instr);
          1: gen_ctrl(instr);
          2: gen_memsys(instr);
          default: gen_illegal(instr);
        endcase
      end
    endcase
  endtask

  function automatic string fmt_retire(input retire_t r);
    return $sformatf("{pc %h rd %0d wen %b result %h taken %b next_pc %h ev %0d}",
                     r.pc, r.rd, r.wen, r.result, r.taken, r.next_pc, r.ev);
  endfunction

  task automatic check_retire(input string name, input retire_t exp, input retire_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s: expected %s actual %s", name, fmt_retire(exp),
                         fmt_retire(act)));
    end
  endtask

  // Runs at each falling edge while retire_o is stable
  task automatic check_outputs(input string name);
    retire_t exp;
    if (retire_o.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        fail_run($sformatf("In %s a retire record appeared with no instruction outstanding",
                           name));
      end else if (due_q[0] != cycle) begin
        fail_run($sformatf("In %s the instruction at pc %h retired at cycle %0d, not %0d",
                           name, exp_q[0].pc, cycle, due_q[0]));
      end else begin
        exp = exp_q.pop_front();
        void'(due_q.pop_front());
        check_retire(name, exp, retire_o);
      end
    end else if (retire_o.valid !== 1'b0) begin
      fail_run($sformatf("In %s the retire valid bit is unknown", name));
    end else if (exp_q.size() != 0 && due_q[0] <= cycle) begin
      fail_run($sformatf("In %s the instruction at pc %h did not retire 3 cycles after strobe",
                         name, exp_q[0].pc));
    end
  endtask

  // Checks the outputs and drives the next input for one clock cycle
  task automatic step(input string name, input logic valid, input logic [31:0] instr);
    retire_t exp;
    check_outputs(name);
    instr_valid_i = valid;
    if (valid) begin
      instr_i = instr;
      pc_i    = pc_next;
      model_exec(instr, pc_next, exp);
      exp_q.push_back(exp);
      due_q.push_back(cycle + 3);
      pc_next = pc_next + 32'd4;
    end else begin
      // Garbage while idle must be ignored
      instr_i = rnd_word();
      pc_i    = rnd_word();
    end
    @(negedge clk_i);
    cycle++;
  endtask

  task automatic run_test(input string name, input int kind);
    logic [31:0] instr;
    pc_next = rnd_word() & ~32'd3;
    last_rd = rand_reg();
    for (int i = 0; i < TEST_LEN; i++) begin
      if (kind == K_DEP) begin
        repeat (rnd(3)) step(name, 1'b0, '0);
      end else begin
        while (rnd(4) == 0) begin
          step(name, 1'b0, '0);
        end
      end
      gen_instr(kind, instr);
      step(name, 1'b1, instr);
    end
    while (exp_q.size() != 0) begin
      step(name, 1'b0, '0);
    end
  endtask

  initial begin
    seed          = 15036;
    clk_i         = 1'b0;
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    cycle         = 0;
    pc_next       = '0;
    last_rd       = '0;
    for (int i = 0; i < `RV32_NUM_REGS; i++) begin
      regs_m[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    // Nothing may retire before the first strobe
    repeat (5) step("ordering", 1'b0, '0);
    run_test("alu", K_ALU);
    run_test("dependency", K_DEP);
    run_test("control_flow", K_CTRL);
    run_test("mem_system", K_MEMSYS);
    run_test("illegal", K_ILLEGAL);
    run_test("ordering", K_MIX);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* rtl/rv32_exec_core.sv */
/*
 * Decode and execute back end of an RV32I core. Takes one instruction
 * per strobe and emits its retire record three cycles later.
 */

`include "rv32_defines.svh"

module rv32_exec_core
  import rv32_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  instr_valid_i,
  input  logic [`RV32_XLEN-1:0] instr_i,
  input  logic [`RV32_XLEN-1:0] pc_i,
  output retire_t               retire_o
);

  decoded_t                dec;
  operand_t                op;
  retire_t                 fwd_ex;
  logic [`RV32_REG_AW-1:0] rf_raddr_a;
  logic [`RV32_REG_AW-1:0] rf_raddr_b;
  logic [`RV32_XLEN-1:0]   rf_rdata_a;
  logic [`RV32_XLEN-1:0]   rf_rdata_b;

  rv32_control_unit i_rv32_control_unit (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .dec_o         (dec)
  );

  rv32_operand_stage i_rv32_operand_stage (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .dec_i        (dec),
    .rf_rdata_a_i (rf_rdata_a),
    .rf_rdata_b_i (rf_rdata_b),
    .rf_raddr_a_o (rf_raddr_a),
    .rf_raddr_b_o (rf_raddr_b),
    .fwd_ex_i     (fwd_ex),
    .fwd_wb_i     (retire_o),
    .op_o         (op)
  );

  rv32_execute_stage i_rv32_execute_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .op_i     (op),
    .fwd_ex_o (fwd_ex),
    .retire_o (retire_o)
  );

  // Retire register drives the write port
  rv32_reg_file i_rv32_reg_file (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (retire_o.valid & retire_o.wen),
    .waddr_i   (retire_o.rd),
    .wdata_i   (retire_o.result)
  );

endmodule

/* rtl/rv32_execute_stage.sv */
/*
 * Execute stage. ALU, branch comparator, link value and next PC.
 * The combinational record feeds forwarding; the registered one retires.
 */

`include "rv32_defines.svh"

module rv32_execute_stage
  import rv32_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  operand_t op_i,
  output retire_t  fwd_ex_o,
  output retire_t  retire_o
);

  logic [`RV32_XLEN-1:0] alu_res;
  logic [`RV32_XLEN-1:0] pc_plus4;
  logic [`RV32_XLEN-1:0] result;
  logic [`RV32_XLEN-1:0] next_pc;
  logic [4:0]            shamt;
  logic                  br_taken;
  retire_t               ret_d;
  retire_t               ret_q;

  assign shamt    = op_i.op_b[4:0];
  assign pc_plus4 = op_i.pc + `RV32_XLEN'(4);

  always_comb begin
    case (op_i.alu_op)
      ALU_SUB:  alu_res = op_i.op_a - op_i.op_b;
      ALU_SLL:  alu_res = op_i.op_a << shamt;
      ALU_SLT:  alu_res = `RV32_XLEN'($signed(op_i.op_a) < $signed(op_i.op_b));
      ALU_SLTU: alu_res = `RV32_XLEN'(op_i.op_a < op_i.op_b);
      ALU_XOR:  alu_res = op_i.op_a ^ op_i.op_b;
      ALU_SRL:  alu_res = op_i.op_a >> shamt;
      ALU_SRA:  alu_res = $unsigned($signed(op_i.op_a) >>> shamt);
      ALU_OR:   alu_res = op_i.op_a | op_i.op_b;
      ALU_AND:  alu_res = op_i.op_a & op_i.op_b;
      default:  alu_res = op_i.op_a + op_i.op_b;
    endcase
  end

  // Unused branch funct3 values never take
  always_comb begin
    case (op_i.br_type)
      BR_BEQ:  br_taken = (op_i.src_a == op_i.src_b);
      BR_BNE:  br_taken = (op_i.src_a != op_i.src_b);
      BR_BLT:  br_taken = ($signed(op_i.src_a) < $signed(op_i.src_b));
      BR_BGE:  br_taken = ($signed(op_i.src_a) >= $signed(op_i.src_b));
      BR_BLTU: br_taken = (op_i.src_a < op_i.src_b);
      BR_BGEU: br_taken = (op_i.src_a >= op_i.src_b);
      default: br_taken = 1'b0;
    endcase
  end

  // Jump and branch targets both come out of the ALU adder
  always_comb begin
    result  = alu_res;
    next_pc = pc_plus4;
    if (op_i.is_lui) begin
      result = op_i.imm;
    end else if (op_i.is_jal) begin
      result  = pc_plus4;
      next_pc = alu_res;
    end else if (op_i.is_jalr) begin
      result  = pc_plus4;
      next_pc = {alu_res[`RV32_XLEN-1:1], 1'b0};
    end else if (op_i.is_branch && br_taken) begin
      next_pc = alu_res;
    end
  end

  always_comb begin
    ret_d.valid   = op_i.valid;
    ret_d.pc      = op_i.pc;
    ret_d.rd      = op_i.rd;
    ret_d.wen     = op_i.wen;
    ret_d.result  = result;
    ret_d.taken   = op_i.is_jal | op_i.is_jalr | (op_i.is_branch & br_taken);
    ret_d.next_pc = next_pc;
    ret_d.ev      = op_i.ev;
  end

  assign fwd_ex_o = ret_d;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ret_q.valid <= 1'b0;
    end else begin
      ret_q <= ret_d;
    end
  end

  assign retire_o = ret_q;

endmodule

/* rtl/rv32_operand_stage.sv */
/*
 * Operand stage. Reads both sources, overrides them with results still
 * in the execute stage or the retire register, selects the ALU operands
 * and registers the operand record.
 */

`include "rv32_defines.svh"

module rv32_operand_stage
  import rv32_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  decoded_t                dec_i,
  input  logic [`RV32_XLEN-1:0]   rf_rdata_a_i,
  input  logic [`RV32_XLEN-1:0]   rf_rdata_b_i,
  output logic [`RV32_REG_AW-1:0] rf_raddr_a_o,
  output logic [`RV32_REG_AW-1:0] rf_raddr_b_o,
  input  retire_t                 fwd_ex_i,
  input  retire_t                 fwd_wb_i,
  output operand_t                op_o
);

  logic [`RV32_XLEN-1:0] rs1_val;
  logic [`RV32_XLEN-1:0] rs2_val;
  operand_t              op_d;
  operand_t              op_q;

  // Execute result takes priority over retire, then the register file
  function automatic logic [`RV32_XLEN-1:0] resolve(
    input logic [`RV32_REG_AW-1:0] rs,
    input logic [`RV32_XLEN-1:0]   rf_val,
    input retire_t                 ex,
    input retire_t                 wb
  );
    logic [`RV32_XLEN-1:0] val;
    val = rf_val;
    if (rs != '0) begin
      if (ex.valid && ex.wen && ex.rd == rs) begin
        val = ex.result;
      end else if (wb.valid && wb.wen && wb.rd == rs) begin
        val = wb.result;
      end
    end
    return val;
  endfunction

  assign rf_raddr_a_o = dec_i.rs1;
  assign rf_raddr_b_o = dec_i.rs2;

  assign rs1_val = resolve(dec_i.rs1, rf_rdata_a_i, fwd_ex_i, fwd_wb_i);
  assign rs2_val = resolve(dec_i.rs2, rf_rdata_b_i, fwd_ex_i, fwd_wb_i);

  always_comb begin
    op_d.valid     = dec_i.valid;
    op_d.pc        = dec_i.pc;
    op_d.rd        = dec_i.rd;
    op_d.wen       = dec_i.wen;
    op_d.alu_op    = dec_i.alu_op;
    op_d.op_a      = dec_i.alu_a_sel ? dec_i.pc : rs1_val;
    op_d.op_b      = dec_i.alu_b_sel ? dec_i.imm : rs2_val;
    op_d.src_a     = rs1_val;
    op_d.src_b     = rs2_val;
    op_d.imm       = dec_i.imm;
    op_d.br_type   = dec_i.br_type;
    op_d.is_branch = dec_i.is_branch;
    op_d.is_jal    = dec_i.is_jal;
    op_d.is_jalr   = dec_i.is_jalr;
    op_d.is_lui    = (dec_i.opcode == OP_LUI);
    op_d.ev        = dec_i.ev;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op_q.valid <= 1'b0;
    end else begin
      op_q <= op_d;
    end
  end

  assign op_o = op_q;

endmodule

/* rtl/rv32_reg_file.sv */
/*
 * Integer register file, two read ports and one write port.
 * x0 reads as zero; a read of the entry being written sees the new value.
 */

`include "rv32_defines.svh"

module rv32_reg_file (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic [`RV32_REG_AW-1:0] raddr_a_i,
  input  logic [`RV32_REG_AW-1:0] raddr_b_i,
  output logic [`RV32_XLEN-1:0]   rdata_a_o,
  output logic [`RV32_XLEN-1:0]   rdata_b_o,
  input  logic                    we_i,
  input  logic [`RV32_REG_AW-1:0] waddr_i,
  input  logic [`RV32_XLEN-1:0]   wdata_i
);

  logic [`RV32_XLEN-1:0] regs [`RV32_NUM_REGS];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `RV32_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Write-through on a same-cycle address match
  always_comb begin
    if (raddr_a_i == '0) begin
      rdata_a_o = '0;
    end else if (we_i && waddr_i == raddr_a_i) begin
      rdata_a_o = wdata_i;
    end else begin
      rdata_a_o = regs[raddr_a_i];
    end
  end

  always_comb begin
    if (raddr_b_i == '0) begin
      rdata_b_o = '0;
    end else if (we_i && waddr_i == raddr_b_i) begin
      rdata_b_o = wdata_i;
    end else begin
      rdata_b_o = regs[raddr_b_i];
    end
  end

endmodule

/* rtl/rv32_control_unit.sv */
/*
 * Decode stage. Splits an RV32I instruction into its control record,
 * selects the immediate by format and flags illegal and system events.
 * The record is registered one cycle after the input strobe.
 */

`include "rv32_defines.svh"

module rv32_control_unit
  import rv32_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  instr_valid_i,
  input  logic [`RV32_XLEN-1:0] instr_i,
  input  logic [`RV32_XLEN-1:0] pc_i,
  output decoded_t              dec_o
);

  rtype_t                instr_r;
  itype_t                instr_it;
  stype_t                instr_s;
  sbtype_t               instr_sb;
  utype_t                instr_u;
  ujtype_t               instr_uj;
  opcode_e               opcode;
  logic [`RV32_XLEN-1:0] imm;
  alu_op_e               alu_op;
  logic                  a_sel;
  logic                  b_sel;
  logic                  wen;
  event_e                ev;
  event_e                sys_ev;
  decoded_t              dec_d;
  decoded_t              dec_q;

  assign instr_r  = rtype_t'(instr_i);
  assign instr_it = itype_t'(instr_i);
  assign instr_s  = stype_t'(instr_i);
  assign instr_sb = sbtype_t'(instr_i);
  assign instr_u  = utype_t'(instr_i);
  assign instr_uj = ujtype_t'(instr_i);
  assign opcode   = opcode_e'(instr_i[6:0]);

  // Sign-extended immediate of the instruction's format
  always_comb begin
    case (opcode)
      OP_STORE: imm = {{20{instr_s.imm11_05[6]}}, instr_s.imm11_05, instr_s.imm04_00};
      OP_BRANCH: imm = {{19{instr_sb.imm12}}, instr_sb.imm12, instr_sb.imm11,
                        instr_sb.imm10_05, instr_sb.imm04_01, 1'b0};
      OP_LUI, OP_AUIPC: imm = {instr_u.imm31_12, 12'b0};
      OP_JAL: imm = {{11{instr_uj.imm20}}, instr_uj.imm20, instr_uj.imm19_12,
                     instr_uj.imm11, instr_uj.imm10_01, 1'b0};
      default: imm = {{20{instr_it.imm11_00[11]}}, instr_it.imm11_00};
    endcase
  end

  // Bit 30 picks SUB for REGREG and the arithmetic shift for both
  always_comb begin
    alu_op = ALU_ADD;
    if (opcode == OP_REGREG || opcode == OP_IMMED) begin
      case (alu_f3_e'(instr_r.funct3))
        F3_ADD: begin
          alu_op = (opcode == OP_REGREG && instr_r.funct7[5]) ? ALU_SUB : ALU_ADD;
        end
        F3_SLL:  alu_op = ALU_SLL;
        F3_SLT:  alu_op = ALU_SLT;
        F3_SLTU: alu_op = ALU_SLTU;
        F3_XOR:  alu_op = ALU_XOR;
        F3_SR:   alu_op = instr_r.funct7[5] ? ALU_SRA : ALU_SRL;
        F3_OR:   alu_op = ALU_OR;
        default: alu_op = ALU_AND;
      endcase
    end
  end

  // Privileged SYSTEM instructions decode by immediate and CSR ops by funct3
  always_comb begin
    sys_ev = EV_NONE;
    case (system_e'(instr_it.funct3))
      SYS_PRIV: begin
        case (instr_it.imm11_00)
          PRIV_ECALL:  sys_ev = EV_ECALL;
          PRIV_EBREAK: sys_ev = EV_EBREAK;
          PRIV_MRET:   sys_ev = EV_MRET;
          PRIV_WFI:    sys_ev = EV_WFI;
          default:     sys_ev = EV_NONE;
        endcase
      end
      SYS_CSRRW, SYS_CSRRS, SYS_CSRRC,
      SYS_CSRRWI, SYS_CSRRSI, SYS_CSRRCI: sys_ev = EV_CSR;
      default: sys_ev = EV_NONE;
    endcase
  end

  // Operand selects, write enable and event
  always_comb begin
    a_sel = 1'b0;
    b_sel = 1'b1;
    wen   = 1'b0;
    ev    = EV_NONE;
    case (opcode)
      OP_REGREG: begin
        b_sel = 1'b0;
        // funct7 bit 0 marks the unsupported M extension
        if (instr_r.funct7[0]) begin
          ev = EV_ILLEGAL;
        end else begin
          wen = 1'b1;
        end
      end
      OP_IMMED, OP_LUI, OP_JALR: wen = 1'b1;
      OP_AUIPC, OP_JAL: begin
        a_sel = 1'b1;
        wen   = 1'b1;
      end
      // ALU forms the branch target as pc + imm
      OP_BRANCH: a_sel = 1'b1;
      OP_LOAD, OP_STORE, OP_MISCMEM: wen = 1'b0;
      OP_SYSTEM: ev = sys_ev;
      default: ev = EV_ILLEGAL;
    endcase
  end

  always_comb begin
    dec_d.valid     = instr_valid_i;
    dec_d.pc        = pc_i;
    dec_d.opcode    = opcode;
    dec_d.rs1       = instr_r.rs1;
    dec_d.rs2       = instr_r.rs2;
    dec_d.rd        = instr_r.rd;
    dec_d.imm       = imm;
    dec_d.alu_op    = alu_op;
    dec_d.alu_a_sel = a_sel;
    dec_d.alu_b_sel = b_sel;
    dec_d.br_type   = branch_e'(instr_sb.funct3);
    dec_d.is_branch = (opcode == OP_BRANCH);
    dec_d.is_jal    = (opcode == OP_JAL);
    dec_d.is_jalr   = (opcode == OP_JALR);
    dec_d.wen       = wen;
    dec_d.ev        = ev;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_q.valid <= 1'b0;
    end else begin
      dec_q <= dec_d;
    end
  end

  assign dec_o = dec_q;

endmodule

/* rtl/rv32_pkg.sv */
/*
 * Types for the RV32 execute core. Opcode and function encodings,
 * instruction field views and the records passed between stages.
 */

`include "rv32_defines.svh"

package rv32_pkg;

  typedef enum logic [6:0] {
    OP_LUI     = 7'b0110111,
    OP_AUIPC   = 7'b0010111,
    OP_JAL     = 7'b1101111,
    OP_JALR    = 7'b1100111,
    OP_BRANCH  = 7'b1100011,
    OP_LOAD    = 7'b0000011,
    OP_STORE   = 7'b0100011,
    OP_IMMED   = 7'b0010011,
    OP_REGREG  = 7'b0110011,
    OP_MISCMEM = 7'b0001111,
    OP_SYSTEM  = 7'b1110011
  } opcode_e;

  // funct3 of REGREG and IMMED
  typedef enum logic [2:0] {
    F3_ADD, F3_SLL, F3_SLT, F3_SLTU, F3_XOR, F3_SR, F3_OR, F3_AND
  } alu_f3_e;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'd0,
    BR_BNE  = 3'd1,
    BR_BLT  = 3'd4,
    BR_BGE  = 3'd5,
    BR_BLTU = 3'd6,
    BR_BGEU = 3'd7
  } branch_e;

  typedef enum logic [2:0] {
    SYS_PRIV   = 3'd0,
    SYS_CSRRW  = 3'd1,
    SYS_CSRRS  = 3'd2,
    SYS_CSRRC  = 3'd3,
    SYS_CSRRWI = 3'd5,
    SYS_CSRRSI = 3'd6,
    SYS_CSRRCI = 3'd7
  } system_e;

  // imm11_00 of the privileged SYSTEM instructions
  localparam logic [11:0] PRIV_ECALL  = 12'h000;
  localparam logic [11:0] PRIV_EBREAK = 12'h001;
  localparam logic [11:0] PRIV_WFI    = 12'h105;
  localparam logic [11:0] PRIV_MRET   = 12'h302;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [2:0] {
    EV_NONE, EV_ILLEGAL, EV_ECALL, EV_EBREAK, EV_MRET, EV_WFI, EV_CSR
  } event_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0] imm11_00;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm11_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm04_00;
    logic [6:0] opcode;
  } stype_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm04_01;
    logic       imm11;
    logic [6:0] opcode;
  } sbtype_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } utype_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } ujtype_t;

  typedef struct packed {
    logic                    valid;
    logic [`RV32_XLEN-1:0]   pc;
    opcode_e                 opcode;
    logic [`RV32_REG_AW-1:0] rs1;
    logic [`RV32_REG_AW-1:0] rs2;
    logic [`RV32_REG_AW-1:0] rd;
    logic [`RV32_XLEN-1:0]   imm;
    alu_op_e                 alu_op;
    // High selects pc for operand a, imm for operand b
    logic                    alu_a_sel;
    logic                    alu_b_sel;
    branch_e                 br_type;
    logic                    is_branch;
    logic                    is_jal;
    logic                    is_jalr;
    logic                    wen;
    event_e                  ev;
  } decoded_t;

  typedef struct packed {
    logic                    valid;
    logic [`RV32_XLEN-1:0]   pc;
    logic [`RV32_REG_AW-1:0] rd;
    logic                    wen;
    alu_op_e                 alu_op;
    logic [`RV32_XLEN-1:0]   op_a;
    logic [`RV32_XLEN-1:0]   op_b;
    // Source values for the branch comparator
    logic [`RV32_XLEN-1:0]   src_a;
    logic [`RV32_XLEN-1:0]   src_b;
    logic [`RV32_XLEN-1:0]   imm;
    branch_e                 br_type;
    logic                    is_branch;
    logic                    is_jal;
    logic                    is_jalr;
    logic                    is_lui;
    event_e                  ev;
  } operand_t;

  typedef struct packed {
    logic                    valid;
    logic [`RV32_XLEN-1:0]   pc;
    logic [`RV32_REG_AW-1:0] rd;
    logic                    wen;
    logic [`RV32_XLEN-1:0]   result;
    logic                    taken;
    logic [`RV32_XLEN-1:0]   next_pc;
    event_e                  ev;
  } retire_t;

endpackage

/* rtl/rv32_defines.svh */
/*
 * Width and size macros shared by the RV32 execute core.
 * Include in any file that sizes data, addresses or register indices.
 */

`ifndef RV32_DEFINES_SVH
`define RV32_DEFINES_SVH

// Data and address width
`define RV32_XLEN 32

// Integer register count, x0 included
`define RV32_NUM_REGS 32

// Register index width
`define RV32_REG_AW 5

`endif
